// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_z80_datapath
FILELIST  = z80_datapath.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: alu/z80_alu.sv
// combinational 8-bit ALU, result and new flags in the same cycle
module z80_alu (
  input  logic [z80_pkg::data_w-1:0] a,
  input  logic [z80_pkg::data_w-1:0] b,
  input  z80_pkg::alu_op_e           op,
  input  z80_pkg::z80_flags_u        f_in,
  output logic [z80_pkg::data_w-1:0] result,
  output z80_pkg::z80_flags_u        f_out
);

  // low nibble sum gives the half carry, the 9-bit sum gives the carry
  logic [4:0]                nib;
  logic [z80_pkg::data_w:0]  full;
  logic                      carry_in;
  logic                      sz_en;

  // only adc feeds the old carry into the adder
  assign carry_in = (op == z80_pkg::alu_adc) ? f_in.bits.c : 1'b0;

  always_comb begin
    // unused bits and untouched flags ride through from f_in
    f_out  = f_in;
    result = b;
    nib    = '0;
    full   = '0;
    sz_en  = 1'b1;

    case (op)
      z80_pkg::alu_add, z80_pkg::alu_adc: begin
        nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, carry_in};
        full = {1'b0, a} + {1'b0, b} + {8'b0, carry_in};
        result = full[z80_pkg::data_w-1:0];
        f_out.bits.h = nib[4];
        f_out.bits.c = full[z80_pkg::data_w];
        // overflow when both operands share a sign and the result does not
        f_out.bits.pv = (a[7] == b[7]) && (result[7] != a[7]);
        f_out.bits.n = 1'b0;
      end
      z80_pkg::alu_sub: begin
        // the top bit of each difference is the borrow
        nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]};
        full = {1'b0, a} - {1'b0, b};
        result = full[z80_pkg::data_w-1:0];
        f_out.bits.h = nib[4];
        f_out.bits.c = full[z80_pkg::data_w];
        // overflow when the signs differ and the result took the sign of b
        f_out.bits.pv = (a[7] != b[7]) && (result[7] != a[7]);
        f_out.bits.n = 1'b1;
      end
      z80_pkg::alu_and: begin
        result = a & b;
        f_out.bits.h = 1'b1;
        f_out.bits.n = 1'b0;
        f_out.bits.c = 1'b0;
        // logic ops report even parity in pv
        f_out.bits.pv = ~^result;
      end
      z80_pkg::alu_or: begin
        result = a | b;
        f_out.bits.h = 1'b0;
        f_out.bits.n = 1'b0;
        f_out.bits.c = 1'b0;
        f_out.bits.pv = ~^result;
      end
      z80_pkg::alu_inc: begin
        // increment works on the b operand so a register on the bus can be bumped
        nib = {1'b0, b[3:0]} + 5'd1;
        result = b + 8'd1;
        f_out.bits.h = nib[4];
        f_out.bits.pv = (result == 8'h80);
        f_out.bits.n = 1'b0;
        // carry is left as it was
      end
      default: begin
        // pass, and any unassigned code, moves b through with no flag change
        result = b;
        sz_en  = 1'b0;
      end
    endcase

    if (sz_en) begin
      f_out.bits.s = result[z80_pkg::data_w-1];
      f_out.bits.z = (result == '0);
    end
  end

endmodule

// File: common/z80_pkg.sv
// ----------------------------------------------------------
// shared definitions for the 8-bit z80 style datapath
// ----------------------------------------------------------
package z80_pkg;

  // width of the data bus and of every 8-bit register
  localparam int data_w = 8;
  // width of the address bus, one register pair
  localparam int addr_w = 16;
  // number of general registers in one bank, b c d e h l
  localparam int num_regs = 6;

  // bit positions inside F, matching the z80 layout
  localparam int flag_s  = 7;
  localparam int flag_z  = 6;
  localparam int flag_h  = 4;
  localparam int flag_pv = 2;
  localparam int flag_n  = 1;
  localparam int flag_c  = 0;

  // general register select, also the index into the register bank
  typedef enum logic [2:0] {b_reg, c_reg, d_reg, e_reg, h_reg, l_reg} reg_id_e;

  // register pair driven onto the address bus
  typedef enum logic [1:0] {bc_pair, de_pair, hl_pair} pair_e;

  // who owns the internal data bus this cycle
  // src_ext leaves the bus to data_in and keeps data_oe low
  typedef enum logic [2:0] {src_ext, src_reg, src_a, src_f, src_temp} data_src_e;

  // operations of the 8-bit ALU
  typedef enum logic [2:0] {
    alu_add, alu_adc, alu_sub, alu_and, alu_or, alu_inc, alu_pass
  } alu_op_e;

  // per-flag override, applied on top of whatever F would load
  typedef enum logic [1:0] {keep, clear, set} flag_force_e;

  typedef struct packed {
    flag_force_e s;
    flag_force_e z;
    flag_force_e h;
    flag_force_e pv;
    flag_force_e n;
    flag_force_e c;
  } z80_flag_force_t;

  // named view of F; bits 5 and 3 are undocumented and simply carried along
  typedef struct packed {
    logic s;
    logic z;
    logic f5;
    logic h;
    logic f3;
    logic pv;
    logic n;
    logic c;
  } z80_flag_bits_t;

  // the bus sees F as a raw byte, the ALU and flag logic see the named bits
  typedef union packed {
    logic [data_w-1:0] raw;
    z80_flag_bits_t    bits;
  } z80_flags_u;

  // control word, one per cycle, acted on in the same cycle
  typedef struct packed {
    data_src_e       data_src;
    reg_id_e         reg_rd;
    logic            reg_wr_en;
    reg_id_e         reg_wr;
    logic            reg_wr_alu;
    logic            addr_en;
    pair_e           addr_pair;
    logic            ld_a;
    logic            a_from_alu;
    logic            ld_f;
    logic            f_from_bus;
    logic            ld_temp;
    logic            alu_b_temp;
    alu_op_e         alu_op;
    z80_flag_force_t flag_force;
    logic            exx;
    logic            ex_af;
  } z80_ctrl_t;

endpackage

// File: regfile/z80_regfile.sv
// general register file with b c d e h l and their shadow bank
module z80_regfile (
  input  logic                         clk,
  input  logic                         rst_n,
  input  z80_pkg::z80_ctrl_t           ctrl,
  input  logic [z80_pkg::data_w-1:0]   bus_byte,
  input  logic [z80_pkg::data_w-1:0]   alu_result,
  output logic [z80_pkg::data_w-1:0]   rd_byte,
  output logic [z80_pkg::addr_w-1:0]   pair_word
);

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  // both banks are indexed by reg_id_e, so b sits at index 0
  logic [z80_pkg::num_regs-1:0][z80_pkg::data_w-1:0] main_q;
  logic [z80_pkg::num_regs-1:0][z80_pkg::data_w-1:0] shadow_q;

  logic [z80_pkg::data_w-1:0] wr_data;
  logic                       wr_valid;
  logic                       rd_valid;

  // the increment path writes the ALU result back, loads take the bus
  assign wr_data = ctrl.reg_wr_alu ? alu_result : bus_byte;

  // codes above l_reg name no register and are ignored
  assign wr_valid = ctrl.reg_wr_en && (ctrl.reg_wr <= z80_pkg::l_reg);
  assign rd_valid = (ctrl.reg_rd <= z80_pkg::l_reg);

  // exx swaps the whole bank in one edge; a write in the same cycle is not allowed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_q   <= '0;
      shadow_q <= '0;
    end else if (ctrl.exx) begin
      main_q   <= shadow_q;
      shadow_q <= main_q;
    end else if (wr_valid) begin
      main_q[ctrl.reg_wr] <= wr_data;
    end
  end

  // ----------------------------------------------------------
  // read ports
  // ----------------------------------------------------------
  // both reads are always live, the top level decides which bus sees them
  always_comb begin
    if (rd_valid) begin
      rd_byte = main_q[ctrl.reg_rd];
    end else begin
      rd_byte = '0;
    end
  end

  // the high register of a pair lands in the upper address byte
  always_comb begin
    case (ctrl.addr_pair)
      z80_pkg::bc_pair: pair_word = {main_q[z80_pkg::b_reg], main_q[z80_pkg::c_reg]};
      z80_pkg::de_pair: pair_word = {main_q[z80_pkg::d_reg], main_q[z80_pkg::e_reg]};
      z80_pkg::hl_pair: pair_word = {main_q[z80_pkg::h_reg], main_q[z80_pkg::l_reg]};
      default:          pair_word = '0;
    endcase
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // the sequencer must never ask for a bank switch and a register write at once,
  // since the write would silently vanish behind the swap
  a_no_exx_with_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ctrl.exx && ctrl.reg_wr_en)
  ) else $error("exx issued together with a register write");

endmodule

// File: sim/tb_z80_datapath.sv
module tb_z80_datapath;

  // the run stops here even if a test never returns
  localparam int max_cycles = 5000;

  logic                       clk;
  logic                       rst_n;
  z80_pkg::z80_ctrl_t         ctrl;
  logic [z80_pkg::data_w-1:0] data_in;
  logic [z80_pkg::data_w-1:0] data_out;
  logic                       data_oe;
  logic [z80_pkg::addr_w-1:0] addr_out;
  logic                       addr_oe;
  z80_pkg::z80_flags_u        flags;

  // reference model state, the same registers the datapath keeps
  logic [7:0] m_regs [6];
  logic [7:0] m_shadow [6];
  logic [7:0] m_a;
  logic [7:0] m_f;
  logic [7:0] m_a_sh;
  logic [7:0] m_f_sh;
  logic [7:0] m_temp;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  z80_datapath i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe),
    .flags    (flags)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------
  // random numbers and checks
  // ----------------------------------------------------------
  // 32-bit fibonacci lfsr with taps 32 22 2 1, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic z80_pkg::reg_id_e rand_reg();
    return z80_pkg::reg_id_e'(3'(rand_bits(3) % 6));
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  // flags follow the z80 rules, worked out with plain integer arithmetic
  task automatic alu_model(input z80_pkg::alu_op_e op, input logic [7:0] a,
                           input logic [7:0] b, input logic [7:0] fin,
                           output logic [7:0] res, output logic [7:0] fo);
    int   sum;
    int   sr;
    logic cin;
    fo  = fin;
    res = b;
    cin = (op == z80_pkg::alu_adc) && fin[z80_pkg::flag_c];
    case (op)
      z80_pkg::alu_add, z80_pkg::alu_adc: begin
        sum = int'(a) + int'(b) + int'(cin);
        res = 8'(sum);
        fo[z80_pkg::flag_h] = (int'(a[3:0]) + int'(b[3:0]) + int'(cin)) > 15;
        fo[z80_pkg::flag_c] = sum > 255;
        sr = int'($signed(a)) + int'($signed(b)) + int'(cin);
        fo[z80_pkg::flag_pv] = (sr > 127) || (sr < -128);
        fo[z80_pkg::flag_n] = 1'b0;
      end
      z80_pkg::alu_sub: begin
        res = a - b;
        fo[z80_pkg::flag_h] = a[3:0] < b[3:0];
        fo[z80_pkg::flag_c] = a < b;
        sr = int'($signed(a)) - int'($signed(b));
        fo[z80_pkg::flag_pv] = (sr > 127) || (sr < -128);
        fo[z80_pkg::flag_n] = 1'b1;
      end
      z80_pkg::alu_and, z80_pkg::alu_or: begin
        res = (op == z80_pkg::alu_and) ? (a & b) : (a | b);
        fo[z80_pkg::flag_h] = (op == z80_pkg::alu_and);
        fo[z80_pkg::flag_n] = 1'b0;
        fo[z80_pkg::flag_c] = 1'b0;
        // an even count of ones sets pv
        fo[z80_pkg::flag_pv] = ($countones(res) % 2) == 0;
      end
      z80_pkg::alu_inc: begin
        res = b + 8'd1;
        fo[z80_pkg::flag_h] = (b[3:0] == 4'hf);
        fo[z80_pkg::flag_pv] = (res == 8'h80);
        fo[z80_pkg::flag_n] = 1'b0;
      end
      default: return;
    endcase
    fo[z80_pkg::flag_s] = res[7];
    fo[z80_pkg::flag_z] = (res == 8'h00);
  endtask

  // s sits in the top field of the override word, c in the bottom one
  function automatic logic [7:0] apply_overrides(input logic [7:0] f,
                                                 input z80_pkg::z80_flag_force_t ff);
    logic [11:0] codes;
    logic [7:0]  res;
    int          pos [6];
    codes = ff;
    res   = f;
    pos   = '{z80_pkg::flag_s, z80_pkg::flag_z, z80_pkg::flag_h,
              z80_pkg::flag_pv, z80_pkg::flag_n, z80_pkg::flag_c};
    for (int i = 0; i < 6; i++) begin
      if (codes[11-2*i -: 2] == z80_pkg::set) begin
        res[pos[i]] = 1'b1;
      end else if (codes[11-2*i -: 2] == z80_pkg::clear) begin
        res[pos[i]] = 1'b0;
      end
    end
    return res;
  endfunction

  function automatic logic [7:0] bus_model(input z80_pkg::z80_ctrl_t c, input logic [7:0] din);
    case (c.data_src)
      z80_pkg::src_reg:  return m_regs[c.reg_rd];
      z80_pkg::src_a:    return m_a;
      z80_pkg::src_f:    return m_f;
      z80_pkg::src_temp: return m_temp;
      default:           return din;
    endcase
  endfunction

  // the high register of each pair is the upper address byte
  function automatic logic [15:0] pair_model(input z80_pkg::pair_e p);
    case (p)
      z80_pkg::bc_pair: return {m_regs[z80_pkg::b_reg], m_regs[z80_pkg::c_reg]};
      z80_pkg::de_pair: return {m_regs[z80_pkg::d_reg], m_regs[z80_pkg::e_reg]};
      default:          return {m_regs[z80_pkg::h_reg], m_regs[z80_pkg::l_reg]};
    endcase
  endfunction

  // all next values come from the state before the edge
  task automatic clock_model(input z80_pkg::z80_ctrl_t c, input logic [7:0] din);
    logic [7:0] bus;
    logic [7:0] opb;
    logic [7:0] res;
    logic [7:0] nf;
    logic [7:0] tmp;
    bus = bus_model(c, din);
    opb = c.alu_b_temp ? m_temp : bus;
    alu_model(c.alu_op, m_a, opb, m_f, res, nf);
    if (c.exx) begin
      for (int i = 0; i < 6; i++) begin
        tmp = m_regs[i];
        m_regs[i] = m_shadow[i];
        m_shadow[i] = tmp;
      end
    end else if (c.reg_wr_en) begin
      m_regs[c.reg_wr] = c.reg_wr_alu ? res : bus;
    end
    if (c.ld_temp) begin
      m_temp = bus;
    end
    if (c.ex_af) begin
      {m_a, m_a_sh} = {m_a_sh, m_a};
      {m_f, m_f_sh} = {m_f_sh, m_f};
    end else begin
      if (c.ld_a) begin
        m_a = c.a_from_alu ? res : bus;
      end
      tmp = c.f_from_bus ? bus : (c.ld_f ? nf : m_f);
      m_f = apply_overrides(tmp, c.flag_force);
    end
  endtask

  // ----------------------------------------------------------
  // one control word per cycle
  // ----------------------------------------------------------
  // outputs are sampled at the falling edge, half a cycle after the drive
  task automatic do_cycle(input z80_pkg::z80_ctrl_t c, input logic [7:0] din);
    ctrl    = c;
    data_in = din;
    @(negedge clk);
    check_val("data_oe", 16'(data_oe), 16'(c.data_src != z80_pkg::src_ext));
    if (c.data_src != z80_pkg::src_ext) begin
      check_val("data_out", 16'(data_out), 16'(bus_model(c, din)));
    end
    check_val("addr_oe", 16'(addr_oe), 16'(c.addr_en));
    if (c.addr_en) begin
      check_val("addr_out", addr_out, pair_model(c.addr_pair));
    end
    check_val("flags", 16'(flags.raw), 16'(m_f));
    @(posedge clk);
    #2;
    clock_model(c, din);
  endtask

  task automatic write_reg(input z80_pkg::reg_id_e r, input logic [7:0] v);
    z80_pkg::z80_ctrl_t c;
    c = '0;
    c.reg_wr_en = 1'b1;
    c.reg_wr = r;
    do_cycle(c, v);
  endtask

  // data_in carries noise while an inside source owns the bus
  task automatic read_regs();
    z80_pkg::z80_ctrl_t c;
    c = '0;
    c.data_src = z80_pkg::src_reg;
    for (int i = 0; i < 6; i++) begin
      c.reg_rd = z80_pkg::reg_id_e'(3'(i));
      do_cycle(c, 8'(rand_bits(8)));
    end
  endtask

  task automatic load_af(input logic [7:0] a, input logic [7:0] f);
    z80_pkg::z80_ctrl_t c;
    c = '0;
    c.ld_a = 1'b1;
    do_cycle(c, a);
    c = '0;
    c.f_from_bus = 1'b1;
    do_cycle(c, f);
  endtask

  task automatic read_af();
    z80_pkg::z80_ctrl_t c;
    c = '0;
    c.data_src = z80_pkg::src_a;
    do_cycle(c, 8'(rand_bits(8)));
    c.data_src = z80_pkg::src_f;
    do_cycle(c, 8'(rand_bits(8)));
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (errors == errs_before) ? "ok" : "FAILED",
             errors - errs_before);
  endtask

  // a stuck test still ends the run
  initial begin
    for (int n = 0; n < max_cycles; n++) begin
      @(posedge clk);
    end
    $display("timeout: the tests did not finish within %0d clock cycles", max_cycles);
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  initial begin
    z80_pkg::z80_ctrl_t c;
    z80_pkg::reg_id_e   r;
    logic [7:0]         v;
    logic [11:0]        ffr;
    logic [1:0]         code;
    int                 errs;

    lfsr = 32'h2fce;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    ctrl = '0;
    data_in = '0;
    rst_n = 1'b0;
    for (int i = 0; i < 6; i++) begin
      m_regs[i] = '0;
      m_shadow[i] = '0;
    end
    {m_a, m_f, m_a_sh, m_f_sh, m_temp} = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // idle word first, then every register onto the bus
    errs = errors;
    do_cycle('0, 8'h00);
    read_regs();
    end_test("reset", errs);

    errs = errors;
    for (int k = 0; k < 24; k++) begin
      write_reg(rand_reg(), 8'(rand_bits(8)));
      read_regs();
      c = '0;
      c.addr_en = 1'b1;
      for (int p = 0; p < 3; p++) begin
        c.addr_pair = z80_pkg::pair_e'(2'(p));
        do_cycle(c, 8'(rand_bits(8)));
      end
    end
    end_test("regs", errs);

    // A gets a fresh byte, TEMP another, then one op with a bus or TEMP operand
    errs = errors;
    for (int k = 0; k < 30; k++) begin
      c = '0;
      c.ld_a = 1'b1;
      do_cycle(c, 8'(rand_bits(8)));
      c = '0;
      c.ld_temp = 1'b1;
      do_cycle(c, 8'(rand_bits(8)));
      c = '0;
      c.alu_op = z80_pkg::alu_op_e'(3'(rand_bits(3) % 5));
      c.alu_b_temp = 1'(rand_bits(1));
      c.ld_a = 1'b1;
      c.a_from_alu = 1'b1;
      c.ld_f = 1'b1;
      do_cycle(c, 8'(rand_bits(8)));
      read_af();
    end
    end_test("alu", errs);

    // the first pass hits the 7fh to 80h overflow case
    errs = errors;
    for (int k = 0; k < 16; k++) begin
      r = rand_reg();
      v = (k == 0) ? 8'h7f : 8'(rand_bits(8));
      write_reg(r, v);
      c = '0;
      c.data_src = z80_pkg::src_reg;
      c.reg_rd = r;
      c.alu_op = z80_pkg::alu_inc;
      c.reg_wr_en = 1'b1;
      c.reg_wr = r;
      c.reg_wr_alu = 1'b1;
      c.ld_f = 1'b1;
      do_cycle(c, 8'(rand_bits(8)));
      c = '0;
      c.data_src = z80_pkg::src_reg;
      c.reg_rd = r;
      do_cycle(c, 8'(rand_bits(8)));
      // the read word is still applied, so the bus shows the bumped register
      check_val("inc_value", 16'(data_out), 16'(8'(v + 8'd1)));
    end
    end_test("inc", errs);

    // fill both banks with different bytes, then swap back and forth
    errs = errors;
    for (int i = 0; i < 6; i++) begin
      write_reg(z80_pkg::reg_id_e'(3'(i)), 8'(rand_bits(8)));
    end
    c = '0;
    c.exx = 1'b1;
    do_cycle(c, 8'h00);
    for (int i = 0; i < 6; i++) begin
      write_reg(z80_pkg::reg_id_e'(3'(i)), 8'(rand_bits(8)));
    end
    do_cycle(c, 8'h00);
    read_regs();
    do_cycle(c, 8'h00);
    do_cycle(c, 8'h00);
    read_regs();
    load_af(8'(rand_bits(8)), 8'(rand_bits(8)));
    c = '0;
    c.ex_af = 1'b1;
    do_cycle(c, 8'h00);
    load_af(8'(rand_bits(8)), 8'(rand_bits(8)));
    do_cycle(c, 8'h00);
    read_af();
    do_cycle(c, 8'h00);
    do_cycle(c, 8'h00);
    read_af();
    end_test("swap", errs);

    // code 3 names no override, so it folds to keep
    errs = errors;
    for (int k = 0; k < 20; k++) begin
      ffr = '0;
      for (int i = 0; i < 6; i++) begin
        code = 2'(rand_bits(2));
        if (code == 2'd3) begin
          code = 2'd0;
        end
        ffr[2*i +: 2] = code;
      end
      c = '0;
      c.f_from_bus = 1'(rand_bits(1));
      c.flag_force = z80_pkg::z80_flag_force_t'(ffr);
      do_cycle(c, 8'(rand_bits(8)));
      c = '0;
      c.data_src = z80_pkg::src_f;
      do_cycle(c, 8'(rand_bits(8)));
    end
    end_test("flags", errs);

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verilog/z80_acc_flags.sv
// accumulator and flag register with their shadow copies
module z80_acc_flags (
  input  logic                       clk,
  input  logic                       rst_n,
  input  z80_pkg::z80_ctrl_t         ctrl,
  input  logic [z80_pkg::data_w-1:0] bus_byte,
  input  logic [z80_pkg::data_w-1:0] alu_result,
  input  z80_pkg::z80_flags_u        alu_flags,
  output logic [z80_pkg::data_w-1:0] a_q,
  output z80_pkg::z80_flags_u        f_q
);

  logic [z80_pkg::data_w-1:0] a_sh_q;
  z80_pkg::z80_flags_u        f_sh_q;
  logic [z80_pkg::data_w-1:0] a_next;
  z80_pkg::z80_flags_u        f_base;
  z80_pkg::z80_flags_u        f_next;
  logic                       f_load;
  logic                       force_any;

  // resolve one override against the value F would otherwise take
  function automatic logic apply_force(input logic cur, input z80_pkg::flag_force_e frc);
    case (frc)
      z80_pkg::set:   return 1'b1;
      z80_pkg::clear: return 1'b0;
      default:        return cur;
    endcase
  endfunction

  assign a_next = ctrl.a_from_alu ? alu_result : bus_byte;

  // ----------------------------------------------------------
  // next F: bus or ALU first, then the per-flag overrides
  // ----------------------------------------------------------
  always_comb begin
    if (ctrl.f_from_bus) begin
      f_base.raw = bus_byte;
    end else if (ctrl.ld_f) begin
      f_base = alu_flags;
    end else begin
      f_base = f_q;
    end

    f_next = f_base;
    f_next.raw[z80_pkg::flag_s]  = apply_force(f_base.raw[z80_pkg::flag_s], ctrl.flag_force.s);
    f_next.raw[z80_pkg::flag_z]  = apply_force(f_base.raw[z80_pkg::flag_z], ctrl.flag_force.z);
    f_next.raw[z80_pkg::flag_h]  = apply_force(f_base.raw[z80_pkg::flag_h], ctrl.flag_force.h);
    f_next.raw[z80_pkg::flag_pv] = apply_force(f_base.raw[z80_pkg::flag_pv], ctrl.flag_force.pv);
    f_next.raw[z80_pkg::flag_n]  = apply_force(f_base.raw[z80_pkg::flag_n], ctrl.flag_force.n);
    f_next.raw[z80_pkg::flag_c]  = apply_force(f_base.raw[z80_pkg::flag_c], ctrl.flag_force.c);

    // any override on its own is enough to load F
    force_any = (ctrl.flag_force.s != z80_pkg::keep) || (ctrl.flag_force.z != z80_pkg::keep)
             || (ctrl.flag_force.h != z80_pkg::keep) || (ctrl.flag_force.pv != z80_pkg::keep)
             || (ctrl.flag_force.n != z80_pkg::keep) || (ctrl.flag_force.c != z80_pkg::keep);
    f_load = ctrl.ld_f || ctrl.f_from_bus || force_any;
  end

  // ex af swaps both pairs at once and takes precedence over any load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q    <= '0;
      f_q    <= '0;
      a_sh_q <= '0;
      f_sh_q <= '0;
    end else if (ctrl.ex_af) begin
      a_q    <= a_sh_q;
      a_sh_q <= a_q;
      f_q    <= f_sh_q;
      f_sh_q <= f_q;
    end else begin
      if (ctrl.ld_a) begin
        a_q <= a_next;
      end
      if (f_load) begin
        f_q <= f_next;
      end
    end
  end

  // a load in the same cycle as ex af would be lost behind the swap
  a_no_ex_af_with_load: assert property (
    @(posedge clk) disable iff (!rst_n)
    ctrl.ex_af |-> !(ctrl.ld_a || ctrl.ld_f || ctrl.f_from_bus)
  ) else $error("ex af issued together with an A or F load");

  // F has one load source per cycle
  a_one_f_source: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ctrl.ld_f && ctrl.f_from_bus)
  ) else $error("F loaded from ALU and bus in the same cycle");

endmodule

// File: verilog/z80_datapath.sv
// top of the 8-bit datapath: internal bus, TEMP and the external bus outputs
module z80_datapath (
  input  logic                       clk,
  input  logic                       rst_n,
  input  z80_pkg::z80_ctrl_t         ctrl,
  input  logic [z80_pkg::data_w-1:0] data_in,
  output logic [z80_pkg::data_w-1:0] data_out,
  output logic                       data_oe,
  output logic [z80_pkg::addr_w-1:0] addr_out,
  output logic                       addr_oe,
  output z80_pkg::z80_flags_u        flags
);

  // ----------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------
  logic [z80_pkg::data_w-1:0] bus_byte;
  logic [z80_pkg::data_w-1:0] rd_byte;
  logic [z80_pkg::addr_w-1:0] pair_word;
  logic [z80_pkg::data_w-1:0] alu_b;
  logic [z80_pkg::data_w-1:0] alu_result;
  z80_pkg::z80_flags_u        alu_flags;
  logic [z80_pkg::data_w-1:0] a_q;
  z80_pkg::z80_flags_u        f_q;
  logic [z80_pkg::data_w-1:0] temp_q;

  // the encoded source field means only one driver can ever be chosen
  always_comb begin
    case (ctrl.data_src)
      z80_pkg::src_ext:  bus_byte = data_in;
      z80_pkg::src_reg:  bus_byte = rd_byte;
      z80_pkg::src_a:    bus_byte = a_q;
      z80_pkg::src_f:    bus_byte = f_q.raw;
      z80_pkg::src_temp: bus_byte = temp_q;
      default:           bus_byte = '0;
    endcase
  end

  // external data only drives in when nobody inside owns the bus
  assign data_oe  = (ctrl.data_src != z80_pkg::src_ext);
  assign data_out = bus_byte;

  // the address bus only ever carries a register pair here
  assign addr_out = pair_word;
  assign addr_oe  = ctrl.addr_en;

  // the control unit branches on these
  assign flags = f_q;

  // TEMP latches an operand off the bus so it can feed the ALU later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      temp_q <= '0;
    end else if (ctrl.ld_temp) begin
      temp_q <= bus_byte;
    end
  end

  assign alu_b = ctrl.alu_b_temp ? temp_q : bus_byte;

  // ----------------------------------------------------------
  // blocks
  // ----------------------------------------------------------
  z80_regfile i_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .bus_byte   (bus_byte),
    .alu_result (alu_result),
    .rd_byte    (rd_byte),
    .pair_word  (pair_word)
  );

  // A is always the first operand, the result never goes onto the bus
  z80_alu i_alu (
    .a      (a_q),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .f_in   (f_q),
    .result (alu_result),
    .f_out  (alu_flags)
  );

  z80_acc_flags i_acc_flags (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .bus_byte   (bus_byte),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .a_q        (a_q),
    .f_q        (f_q)
  );

endmodule

// File: z80_datapath.f
common/z80_pkg.sv
regfile/z80_regfile.sv
alu/z80_alu.sv
verilog/z80_acc_flags.sv
verilog/z80_datapath.sv
sim/tb_z80_datapath.sv
